// File: hdl/aluCore.sv
`timescale 1ns/1ps
`default_nettype none

module aluCore (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           loadA,
    input  logic                           loadB,
    input  logic                           loadOp,
    input  logic                           updateRes,
    input  logic [calcPkg::DataWidth-1:0]  dataIn,
    output logic [calcPkg::DataWidth-1:0]  result,
    output logic [calcPkg::FlagCount-1:0]  flags
);

    import calcPkg::*;

    ////////////////////////////////
    // Operand and opcode registers
    ////////////////////////////////

    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;
    aluOpT                aluOp;

    always_ff @(posedge clk) begin
        if (loadA) begin
            opA <= dataIn;
        end
        if (loadB) begin
            opB <= dataIn;
        end
        // Opcode sits in the two low switches
        if (loadOp) begin
            aluOp <= aluOpT'(dataIn[1:0]);
        end
    end

    ////////////////////////////////
    // ALU
    ////////////////////////////////

    // One extra bit for carry and borrow
    logic [DataWidth:0]   sumExt;
    logic [DataWidth:0]   diffExt;
    logic [DataWidth-1:0] aluResult;
    logic                 carry;
    logic                 overflow;

    assign sumExt  = {1'b0, opA} + {1'b0, opB};
    assign diffExt = {1'b0, opA} - {1'b0, opB};

    always_comb begin
        case (aluOp)
            opAdd: begin
                aluResult = sumExt[DataWidth-1:0];
                carry     = sumExt[DataWidth];
                // Same-sign operands, result sign flipped
                overflow  = (opA[DataWidth-1] == opB[DataWidth-1])
                         && (aluResult[DataWidth-1] != opA[DataWidth-1]);
            end
            opSub: begin
                aluResult = diffExt[DataWidth-1:0];
                // Borrow when A < B unsigned
                carry     = diffExt[DataWidth];
                // Opposite-sign operands, result sign differs from A
                overflow  = (opA[DataWidth-1] != opB[DataWidth-1])
                         && (aluResult[DataWidth-1] != opA[DataWidth-1]);
            end
            opOr: begin
                aluResult = opA | opB;
                carry     = 1'b0;
                overflow  = 1'b0;
            end
            default: begin
                aluResult = opA & opB;
                carry     = 1'b0;
                overflow  = 1'b0;
            end
        endcase
    end

    ////////////////////////////////
    // Result and NZCV registers
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else if (updateRes) begin
            result <= aluResult;
            flags  <= {aluResult[DataWidth-1], (aluResult == '0), carry, overflow};
        end
    end

endmodule

`default_nettype wire

// File: hdl/bcdDigitCell.sv
`timescale 1ns/1ps
`default_nettype none

module bcdDigitCell (
    input  logic       clk,
    input  logic       reset,
    input  logic       clear,
    input  logic       step,
    input  logic       carryIn,
    output logic       carryOut,
    output logic [3:0] digit
);

    // Digit after the add-3 correction
    logic [3:0] adjusted;

    // Five or more would exceed nine after doubling
    assign adjusted = (digit >= 4'd5) ? digit + 4'd3 : digit;

    // Bit that moves into the next decimal place
    assign carryOut = adjusted[3];

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            digit <= 4'd0;
        end else if (step) begin
            // Double and bring in the lower bit
            digit <= {adjusted[2:0], carryIn};
        end
    end

endmodule

`default_nettype wire

// File: hdl/bcdSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bcdSequencer #(
    parameter int Width = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [Width-1:0] word,
    output logic             shiftIn,
    output logic             step,
    output logic             clear,
    output logic             done
);

    // Counts 0 for capture, then 1 to Width for the shifts
    localparam int CountWidth = $clog2(Width + 1);

    logic [CountWidth-1:0] stepCount;
    logic [Width-1:0]      shiftReg;
    logic                  lastStep;

    assign lastStep = (stepCount == CountWidth'(Width));

    ////////////////////////////////
    // Step counter
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stepCount <= '0;
            done      <= 1'b0;
        end else begin
            if (lastStep) begin
                stepCount <= '0;
            end else begin
                stepCount <= stepCount + 1'b1;
            end
            // Digits are final during the cycle after the last shift
            done <= lastStep;
        end
    end

    ////////////////////////////////
    // Word capture and MSB-first shift
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (stepCount == '0) begin
            shiftReg <= word;
        end else begin
            shiftReg <= {shiftReg[Width-2:0], 1'b0};
        end
    end

    // Capture cycle wipes the digit cells
    assign clear   = (stepCount == '0);
    assign step    = !clear;

    // Top bit feeds the lowest digit cell
    assign shiftIn = shiftReg[Width-1];

endmodule

`default_nettype wire

// File: hdl/calcPkg.sv
`default_nettype none

package calcPkg;

    ////////////////////////////////
    // Datapath sizes
    ////////////////////////////////

    // Operands, result and switch input
    localparam int DataWidth = 16;

    // Flag vector {N, Z, C, V}
    localparam int FlagCount = 4;

    // Decimal digits for a DataWidth-bit unsigned value
    localparam int BcdDigits = 5;

    // Scanned positions on the board
    localparam int DisplayDigits = 8;

    ////////////////////////////////
    // Encodings
    ////////////////////////////////

    // Entry FSM states, also shown on the status LEDs
    typedef enum logic [2:0] {
        waitA  = 3'd0,
        loadA  = 3'd1,
        waitB  = 3'd2,
        loadB  = 3'd3,
        waitOp = 3'd4,
        loadOp = 3'd5,
        update = 3'd6
    } calcStateT;

    // ALU opcodes, taken from the low bits of the data input
    typedef enum logic [1:0] {
        opAdd = 2'd0,
        opSub = 2'd1,
        opOr  = 2'd2,
        opAnd = 2'd3
    } aluOpT;

endpackage

`default_nettype wire

// File: hdl/displayScan.sv
`timescale 1ns/1ps
`default_nettype none

module displayScan #(
    parameter int ScanDivider = 100000
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             done,
    input  logic                             displayFormat,
    input  logic [calcPkg::BcdDigits*4-1:0]  bcdDigits,
    input  logic [calcPkg::DataWidth-1:0]    hexWord,
    output logic [6:0]                       segments,
    output logic [7:0]                       anodes
);

    import calcPkg::*;

    localparam int DivWidth = (ScanDivider > 1) ? $clog2(ScanDivider) : 1;
    localparam int PosWidth = $clog2(DisplayDigits);
    localparam int HexDigits = DataWidth / 4;

    logic [BcdDigits*4-1:0] bcdLatched;
    logic [DivWidth-1:0]    divCount;
    logic                   scanTick;
    logic                   scanActive;
    logic [PosWidth-1:0]    position;
    logic [3:0]             nibble;

    ////////////////////////////////
    // Converter output latch
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bcdLatched <= '0;
        end else if (done) begin
            bcdLatched <= bcdDigits;
        end
    end

    ////////////////////////////////
    // Scan timing
    ////////////////////////////////

    assign scanTick = (divCount == DivWidth'(ScanDivider - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            divCount   <= '0;
            scanActive <= 1'b0;
            position   <= '0;
        end else begin
            if (scanTick) begin
                divCount <= '0;
                // First tick lights digit 0, later ones advance
                if (scanActive) begin
                    position <= position + 1'b1;
                end
                scanActive <= 1'b1;
            end else begin
                divCount <= divCount + 1'b1;
            end
        end
    end

    // One-cold, all dark until scanning starts
    assign anodes = scanActive ? ~(8'b1 << position) : 8'hFF;

    ////////////////////////////////
    // Digit selection and glyphs
    ////////////////////////////////

    always_comb begin
        nibble = 4'd0;
        if (displayFormat) begin
            // Unsigned decimal, upper positions blank to zero
            if (position < BcdDigits) begin
                nibble = bcdLatched[position*4 +: 4];
            end
        end else if (position < HexDigits) begin
            nibble = hexWord[position*4 +: 4];
        end
    end

    // Segments a..g from the top bit, low means lit
    always_comb begin
        case (nibble)
            4'h0:    segments = 7'b0000001;
            4'h1:    segments = 7'b1001111;
            4'h2:    segments = 7'b0010010;
            4'h3:    segments = 7'b0000110;
            4'h4:    segments = 7'b1001100;
            4'h5:    segments = 7'b0100100;
            4'h6:    segments = 7'b0100000;
            4'h7:    segments = 7'b0001111;
            4'h8:    segments = 7'b0000000;
            4'h9:    segments = 7'b0000100;
            4'hA:    segments = 7'b0001000;
            // Lower-case b
            4'hB:    segments = 7'b1100000;
            4'hC:    segments = 7'b0110001;
            // Lower-case d
            4'hD:    segments = 7'b1000010;
            4'hE:    segments = 7'b0110000;
            default: segments = 7'b0111000;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rpnCalcTop.sv
`timescale 1ns/1ps
`default_nettype none

module rpnCalcTop #(
    parameter int ScanDivider = 100000
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           enter,
    input  logic                           undo,
    input  logic                           displayFormat,
    input  logic [calcPkg::DataWidth-1:0]  dataIn,
    output logic [6:0]                     segments,
    output logic [7:0]                     anodes,
    output logic [calcPkg::FlagCount-1:0]  flags,
    output calcPkg::calcStateT             status,
    output logic [calcPkg::DataWidth-1:0]  result
);

    import calcPkg::*;

    // Control strobes
    logic loadA;
    logic loadB;
    logic loadOp;
    logic updateRes;
    logic showResult;

    // Converter interconnect
    logic [DataWidth-1:0]   shownWord;
    logic                   shiftIn;
    logic                   step;
    logic                   clear;
    logic                   done;
    logic [BcdDigits-1:0]   carryIn;
    logic [BcdDigits*4-1:0] bcdDigits;

    ////////////////////////////////
    // Entry control and ALU
    ////////////////////////////////

    rpnControl control_i (
        .clk        (clk),
        .reset      (reset),
        .enter      (enter),
        .undo       (undo),
        .status     (status),
        .loadA      (loadA),
        .loadB      (loadB),
        .loadOp     (loadOp),
        .updateRes  (updateRes),
        .showResult (showResult)
    );

    aluCore alu_i (
        .clk       (clk),
        .reset     (reset),
        .loadA     (loadA),
        .loadB     (loadB),
        .loadOp    (loadOp),
        .updateRes (updateRes),
        .dataIn    (dataIn),
        .result    (result),
        .flags     (flags)
    );

    // Result while it is meaningful, live switches otherwise
    assign shownWord = showResult ? result : dataIn;

    ////////////////////////////////
    // Binary to BCD
    ////////////////////////////////

    bcdSequencer #(
        .Width (DataWidth)
    ) sequencer_i (
        .clk     (clk),
        .reset   (reset),
        .word    (shownWord),
        .shiftIn (shiftIn),
        .step    (step),
        .clear   (clear),
        .done    (done)
    );

    // Serial bit enters the ones digit
    assign carryIn[0] = shiftIn;

    for (genvar i = 0; i < BcdDigits; i++) begin : genDigit
        // Top digit never carries out for a DataWidth-bit word
        if (i < BcdDigits - 1) begin : genChained
            bcdDigitCell cell_i (
                .clk      (clk),
                .reset    (reset),
                .clear    (clear),
                .step     (step),
                .carryIn  (carryIn[i]),
                .carryOut (carryIn[i+1]),
                .digit    (bcdDigits[i*4 +: 4])
            );
        end else begin : genLast
            bcdDigitCell cell_i (
                .clk      (clk),
                .reset    (reset),
                .clear    (clear),
                .step     (step),
                .carryIn  (carryIn[i]),
                .carryOut (),
                .digit    (bcdDigits[i*4 +: 4])
            );
        end
    end

    ////////////////////////////////
    // Display
    ////////////////////////////////

    displayScan #(
        .ScanDivider (ScanDivider)
    ) scan_i (
        .clk           (clk),
        .reset         (reset),
        .done          (done),
        .displayFormat (displayFormat),
        .bcdDigits     (bcdDigits),
        .hexWord       (shownWord),
        .segments      (segments),
        .anodes        (anodes)
    );

endmodule

`default_nettype wire

// File: hdl/rpnControl.sv
`timescale 1ns/1ps
`default_nettype none

module rpnControl (
    input  logic              clk,
    input  logic              reset,
    input  logic              enter,
    input  logic              undo,
    output calcPkg::calcStateT status,
    output logic              loadA,
    output logic              loadB,
    output logic              loadOp,
    output logic              updateRes,
    output logic              showResult
);

    import calcPkg::*;

    ////////////////////////////////
    // Button edge detection
    ////////////////////////////////

    // Previous-cycle copies of the buttons
    logic enterQ;
    logic undoQ;

    // Single-cycle press pulses
    logic enterPress;
    logic undoPress;

    always_ff @(posedge clk) begin
        if (reset) begin
            enterQ <= 1'b0;
            undoQ  <= 1'b0;
        end else begin
            enterQ <= enter;
            undoQ  <= undo;
        end
    end

    // High only on the first cycle of a press
    assign enterPress = enter & ~enterQ;
    assign undoPress  = undo & ~undoQ;

    ////////////////////////////////
    // Entry FSM
    ////////////////////////////////

    calcStateT state;
    calcStateT nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= waitA;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            // Only the wait states look at the buttons
            // Undo takes priority over a simultaneous Enter
            waitA: begin
                if (enterPress && !undoPress) begin
                    nextState = calcPkg::loadA;
                end
            end
            waitB: begin
                if (undoPress) begin
                    nextState = waitA;
                end else if (enterPress) begin
                    nextState = calcPkg::loadB;
                end
            end
            waitOp: begin
                if (undoPress) begin
                    nextState = waitB;
                end else if (enterPress) begin
                    nextState = calcPkg::loadOp;
                end
            end
            // Load and update states last one cycle
            calcPkg::loadA:  nextState = waitB;
            calcPkg::loadB:  nextState = waitOp;
            calcPkg::loadOp: nextState = update;
            update:          nextState = waitA;
            default:         nextState = waitA;
        endcase
    end

    ////////////////////////////////
    // Strobe decode
    ////////////////////////////////

    assign status    = state;
    assign loadA     = (state == calcPkg::loadA);
    assign loadB     = (state == calcPkg::loadB);
    assign loadOp    = (state == calcPkg::loadOp);
    assign updateRes = (state == update);

    // Result on display except while B or the opcode is being keyed in
    assign showResult = (state == waitA) || (state == calcPkg::loadA)
                     || (state == calcPkg::loadOp) || (state == update);

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hdl/calcPkg.sv
hdl/bcdDigitCell.sv
hdl/bcdSequencer.sv
hdl/rpnControl.sv
hdl/aluCore.sv
hdl/displayScan.sv
hdl/rpnCalcTop.sv
test/rpnCalcTb.sv

// File: include/rpnCalcChecks.svh
`ifndef RPN_CALC_CHECKS_SVH
`define RPN_CALC_CHECKS_SVH

////////////////////////////////
// Value comparisons
////////////////////////////////

task automatic compareResult(input logic [DataWidth-1:0] actual,
                             input logic [DataWidth-1:0] expected);
    if (actual !== expected) begin
        $display("MISMATCH result: got 0x%h, expected 0x%h", actual, expected);
        stopWithFailure("Result register holds the wrong value");
    end
endtask

// Flags are {N, Z, C, V}
task automatic compareFlags(input logic [FlagCount-1:0] actual,
                            input logic [FlagCount-1:0] expected);
    if (actual !== expected) begin
        $display("MISMATCH flags: got 0x%h, expected 0x%h", actual, expected);
        stopWithFailure("Flag register holds the wrong value");
    end
endtask

task automatic compareStatus(input calcStateT actual, input calcStateT expected);
    if (actual !== expected) begin
        $display("MISMATCH status: got 0x%h, expected 0x%h", actual, expected);
        stopWithFailure("Entry FSM is in the wrong state");
    end
endtask

task automatic compareSegments(input logic [6:0] actual, input logic [6:0] expected);
    if (actual !== expected) begin
        $display("MISMATCH segments: got 0x%h, expected 0x%h", actual, expected);
        stopWithFailure("Display shows the wrong glyph");
    end
endtask

task automatic compareAnodes(input logic [7:0] actual, input logic [7:0] expected);
    if (actual !== expected) begin
        $display("MISMATCH anodes: got 0x%h, expected 0x%h", actual, expected);
        stopWithFailure("Anode drive is wrong");
    end
endtask

////////////////////////////////
// Display sampling
////////////////////////////////

// Block until the given position is lit
task automatic waitForAnode(input int pos);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (anodes !== ~(8'b1 << pos)) begin
        if (cycles >= ScanTimeout) begin
            stopWithFailure($sformatf("Timeout: display never lit position %0d", pos));
        end else begin
            cycles++;
            @(negedge clk);
        end
    end
endtask

// One full pass over all eight positions
task automatic checkScan(input logic [DataWidth-1:0] word, input logic decimal);
    for (int pos = 0; pos < DisplayDigits; pos++) begin
        waitForAnode(pos);
        compareSegments(segments, expectedSegments(pos, word, decimal));
    end
endtask

`endif

// File: test/rpnCalcTb.sv
`timescale 1ns/1ps
`default_nettype none

module rpnCalcTb;

    import calcPkg::*;

    // Short scan so a full pass fits in a few dozen cycles
    localparam int ScanDivider  = 4;
    localparam int ScanTimeout  = ScanDivider * DisplayDigits * 2;
    localparam int StatusTimeout = 20;
    // Two conversions, worst case
    localparam int SettleCycles = 2 * (DataWidth + 1);

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 enter;
    logic                 undo;
    logic                 displayFormat;
    logic [DataWidth-1:0] dataIn;
    logic [6:0]           segments;
    logic [7:0]           anodes;
    logic [FlagCount-1:0] flags;
    calcStateT            status;
    logic [DataWidth-1:0] result;

    int                   seed = 23;
    // Last result predicted by the model
    logic [DataWidth-1:0] modelResult = '0;

    rpnCalcTop #(
        .ScanDivider (ScanDivider)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .enter         (enter),
        .undo          (undo),
        .displayFormat (displayFormat),
        .dataIn        (dataIn),
        .segments      (segments),
        .anodes        (anodes),
        .flags         (flags),
        .status        (status),
        .result        (result)
    );

    always #20 clk = ~clk;

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped on first failure");
    endtask

    ////////////////////////////////
    // Reference models
    ////////////////////////////////

    // Returns {N, Z, C, V, result}
    function automatic logic [FlagCount+DataWidth-1:0] expectedAlu(
        input logic [DataWidth-1:0] a,
        input logic [DataWidth-1:0] b,
        input aluOpT                op
    );
        logic [DataWidth-1:0]      r;
        logic                      c;
        logic                      v;
        logic signed [DataWidth:0] wide;
        c = 1'b0;
        v = 1'b0;
        case (op)
            opAdd: begin
                r = a + b;
                c = (32'(a) + 32'(b)) >= (32'd1 << DataWidth);
                // Signed sum that no longer fits in DataWidth bits
                wide = $signed({a[DataWidth-1], a}) + $signed({b[DataWidth-1], b});
                v = wide[DataWidth] != wide[DataWidth-1];
            end
            opSub: begin
                r = a - b;
                // Borrow
                c = a < b;
                wide = $signed({a[DataWidth-1], a}) - $signed({b[DataWidth-1], b});
                v = wide[DataWidth] != wide[DataWidth-1];
            end
            opOr:    r = a | b;
            default: r = a & b;
        endcase
        return {r[DataWidth-1], (r == '0), c, v, r};
    endfunction

    // Active-low glyph for one position
    function automatic logic [6:0] expectedSegments(
        input int                   pos,
        input logic [DataWidth-1:0] word,
        input logic                 decimal
    );
        int         value;
        int         digitVal;
        logic [6:0] lit;
        value    = word;
        digitVal = 0;
        if (decimal && pos < BcdDigits) begin
            for (int i = 0; i < pos; i++) begin
                value = value / 10;
            end
            digitVal = value % 10;
        end else if (!decimal && pos < DataWidth / 4) begin
            digitVal = (value >> (4 * pos)) & 15;
        end
        // Lit segments a..g, top bit is a
        case (digitVal)
            0:       lit = 7'h7E;
            1:       lit = 7'h30;
            2:       lit = 7'h6D;
            3:       lit = 7'h79;
            4:       lit = 7'h33;
            5:       lit = 7'h5B;
            6:       lit = 7'h5F;
            7:       lit = 7'h70;
            8:       lit = 7'h7F;
            9:       lit = 7'h7B;
            10:      lit = 7'h77;
            11:      lit = 7'h1F;
            12:      lit = 7'h4E;
            13:      lit = 7'h3D;
            14:      lit = 7'h4F;
            default: lit = 7'h47;
        endcase
        return ~lit;
    endfunction

    `include "rpnCalcChecks.svh"

    ////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////

    task automatic pressButtons(input logic pushEnter, input logic pushUndo);
        @(posedge clk);
        enter <= pushEnter;
        undo  <= pushUndo;
        @(posedge clk);
        enter <= 1'b0;
        undo  <= 1'b0;
    endtask

    // Switches and Enter change on the same edge
    task automatic enterValue(input logic [DataWidth-1:0] value);
        @(posedge clk);
        dataIn <= value;
        enter  <= 1'b1;
        @(posedge clk);
        enter  <= 1'b0;
    endtask

    task automatic setData(input logic [DataWidth-1:0] value);
        @(posedge clk);
        dataIn <= value;
    endtask

    task automatic setFormat(input logic decimal);
        @(posedge clk);
        displayFormat <= decimal;
    endtask

    task automatic settle();
        repeat (SettleCycles) @(negedge clk);
    endtask

    task automatic waitForStatus(input calcStateT target);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (status !== target) begin
            if (cycles >= StatusTimeout) begin
                stopWithFailure($sformatf("Timeout: status never reached %s", target.name()));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // Status must stay put for a few cycles
    task automatic holdStatus(input calcStateT target, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compareStatus(status, target);
        end
    endtask

    // A, Enter, B, Enter, opcode, Enter, then compare
    task automatic runEntry(input logic [DataWidth-1:0] a,
                            input logic [DataWidth-1:0] b,
                            input logic [DataWidth-1:0] opWord);
        logic [FlagCount+DataWidth-1:0] expected;
        expected = expectedAlu(a, b, aluOpT'(opWord[1:0]));
        enterValue(a);
        waitForStatus(waitB);
        enterValue(b);
        waitForStatus(waitOp);
        enterValue(opWord);
        waitForStatus(waitA);
        compareResult(result, expected[DataWidth-1:0]);
        compareFlags(flags, expected[DataWidth +: FlagCount]);
        modelResult = expected[DataWidth-1:0];
    endtask

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////

    task automatic runRandomEntries();
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        logic [DataWidth-1:0] opWord;
        for (int n = 0; n < 20; n++) begin
            a = $random(seed);
            b = $random(seed);
            // Upper switches are noise, opcode cycles through all four
            opWord = ($random(seed) & ~32'd3) | (n % 4);
            runEntry(a, b, opWord);
        end
    endtask

    initial begin
        reset         = 1'b1;
        enter         = 1'b0;
        undo          = 1'b0;
        displayFormat = 1'b0;
        dataIn        = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Reset state and a blank scan
        @(negedge clk);
        compareStatus(status, waitA);
        compareResult(result, '0);
        compareFlags(flags, '0);
        // Scan has not stepped yet
        compareAnodes(anodes, 8'hFF);
        checkScan('0, 1'b0);

        // Overflow, carry, borrow and zero corners
        runEntry(16'h7FFF, 16'h0001, DataWidth'(opAdd));
        runEntry(16'hFFFF, 16'h0001, DataWidth'(opAdd));
        runEntry(16'h0001, 16'h0002, DataWidth'(opSub));
        runEntry(16'h8000, 16'h0001, DataWidth'(opSub));
        runEntry(16'h1234, 16'h1234, DataWidth'(opSub));
        runEntry(16'hF0F0, 16'h0F0F, DataWidth'(opAnd));
        runEntry(16'hF0F0, 16'h0F0F, DataWidth'(opOr));
        runRandomEntries();

        // Undo from waitB, then a replaced B
        enterValue(16'd100);
        waitForStatus(waitB);
        pressButtons(1'b0, 1'b1);
        waitForStatus(waitA);
        enterValue(16'd100);
        waitForStatus(waitB);
        enterValue(16'd5);
        waitForStatus(waitOp);
        pressButtons(1'b0, 1'b1);
        waitForStatus(waitB);
        runEntryTail(16'd100, 16'd9);

        // Both buttons together behave as Undo
        enterValue(16'd3);
        waitForStatus(waitB);
        enterValue(16'd4);
        waitForStatus(waitOp);
        pressButtons(1'b1, 1'b1);
        waitForStatus(waitB);
        pressButtons(1'b1, 1'b1);
        waitForStatus(waitA);
        pressButtons(1'b1, 1'b1);
        holdStatus(waitA, 3);
        compareResult(result, modelResult);

        // Held Enter advances a single step
        @(posedge clk);
        dataIn <= 16'h0042;
        enter  <= 1'b1;
        repeat (6) @(posedge clk);
        enter  <= 1'b0;
        holdStatus(waitB, 3);
        pressButtons(1'b0, 1'b1);
        waitForStatus(waitA);

        // Hex view of result, then of live switches
        setFormat(1'b0);
        settle();
        checkScan(modelResult, 1'b0);
        enterValue(16'h1234);
        waitForStatus(waitB);
        setData(16'hBEEF);
        settle();
        checkScan(16'hBEEF, 1'b0);

        // Decimal view
        setFormat(1'b1);
        setData(16'hFFFF);
        settle();
        checkScan(16'hFFFF, 1'b1);
        setData(16'd40961);
        settle();
        checkScan(16'd40961, 1'b1);
        pressButtons(1'b0, 1'b1);
        waitForStatus(waitA);
        settle();
        checkScan(modelResult, 1'b1);
        runEntry(16'hFFFF, 16'h0000, DataWidth'(opOr));
        settle();
        checkScan(modelResult, 1'b1);

        $display("No errors");
        $finish;
    end

    // Finishes an entry whose B is typed in waitB, opcode Sub
    task automatic runEntryTail(input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
        logic [FlagCount+DataWidth-1:0] expected;
        expected = expectedAlu(a, b, opSub);
        enterValue(b);
        waitForStatus(waitOp);
        enterValue(DataWidth'(opSub));
        waitForStatus(waitA);
        compareResult(result, expected[DataWidth-1:0]);
        compareFlags(flags, expected[DataWidth +: FlagCount]);
        modelResult = expected[DataWidth-1:0];
    endtask

endmodule

`default_nettype wire
